/* ddr5_types_pkg.sv */
package ddr5_types_pkg;

	parameter int data_width       = 16;
	parameter int burst_length     = 16; // beats per burst, column bits 3..0
	parameter int read_entries_log = 4;  // request index width
	parameter int address_width    = 30;

	typedef struct packed {
		logic [1:0]  bank_group;
		logic [1:0]  bank;
		logic [15:0] row;
		logic [9:0]  column; // 9..4 block, 3..0 beat
	} req_address_type;

	typedef enum logic [2:0] {
		empty,
		started_filling,
		almost_done,
		full,
		waiting,
		returning_data
	} burst_states_type;

	typedef enum logic {
		read,
		write
	} r_type;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge
	} command;

endpackage

/* burst_if.sv */
`timescale 1ns/1ps

interface burst_if #(
	parameter int no_of_bursts = 4
);
	import ddr5_types_pkg::*;

	burst_states_type state [no_of_bursts];
	r_type burst_type [no_of_bursts];
	logic [1:0] bank_group [no_of_bursts];
	logic [1:0] bank [no_of_bursts];
	logic [15:0] row [no_of_bursts];
	logic [5:0] col_block [no_of_bursts]; // column bits 9..4

	command cmd; // valid for a single cycle
	logic [$clog2(no_of_bursts)-1:0] cmd_index;
	logic data_done; // pulse after last beat

	modport store (output state, burst_type, bank_group, bank, row, col_block,
		input cmd, cmd_index, data_done);

	modport ctrl (input state, burst_type, data_done,
		output cmd, cmd_index);

	modport phy (input cmd, cmd_index, bank_group, bank, row, col_block,
		output data_done);

endinterface

/* beat_if.sv */
`timescale 1ns/1ps

interface beat_if #(
	parameter int no_of_bursts = 4
);
	import ddr5_types_pkg::*;

	logic beat_valid; // a beat is on DQ this cycle
	r_type beat_dir;
	logic [$clog2(no_of_bursts)-1:0] beat_slot;
	logic [$clog2(burst_length)-1:0] beat_num;
	logic [data_width-1:0] wr_data;
	logic wr_mask; // entry present for this beat
	logic [data_width-1:0] rd_data;

	modport phy (output beat_valid, beat_dir, beat_slot, beat_num, rd_data,
		input wr_data, wr_mask);

	modport store (input beat_valid, beat_dir, beat_slot, beat_num, rd_data,
		output wr_data, wr_mask);

endinterface

/* burst_store.sv */
`timescale 1ns/1ps

module burst_store #(
	parameter int no_of_bursts = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic arbiter_valid,
	input  ddr5_types_pkg::r_type arbiter_type,
	input  ddr5_types_pkg::req_address_type in_req_address,
	input  logic [ddr5_types_pkg::data_width-1:0] arbiter_data,
	input  logic [ddr5_types_pkg::read_entries_log-1:0] arbiter_index,
	output logic start_new_burst,
	output logic returner_valid,
	output ddr5_types_pkg::r_type returner_type,
	output logic [ddr5_types_pkg::data_width-1:0] returner_data,
	output logic [ddr5_types_pkg::read_entries_log-1:0] returner_index,
	burst_if.store bif,
	beat_if.store beat
);
	import ddr5_types_pkg::*;

	localparam int slot_w = $clog2(no_of_bursts);
	localparam int beat_w = $clog2(burst_length);

	burst_states_type slot_state [no_of_bursts];
	r_type slot_type [no_of_bursts];
	logic [address_width-5:0] slot_block [no_of_bursts]; // bg, bank, row, column block
	logic [read_entries_log-1:0] slot_index [no_of_bursts][burst_length];
	logic [data_width-1:0] slot_data [no_of_bursts][burst_length];
	logic [burst_length-1:0] slot_mask [no_of_bursts];

	logic [slot_w-1:0] fill_slot, open_slot, in_slot, ret_slot;
	logic [3:0] fill_cnt; // requests in the filling burst
	logic [slot_w:0] empty_cnt;
	logic filling, merge, open_new;
	logic ret_any, ret_done;
	logic [burst_length-1:0] ret_mask, ret_onehot;
	logic [beat_w-1:0] ret_beat, req_beat;
	logic [address_width-5:0] req_block;

	assign req_block = in_req_address[address_width-1:4];
	assign req_beat = in_req_address.column[3:0];

	always_comb begin
		filling = (slot_state[fill_slot] == started_filling) ||
			(slot_state[fill_slot] == almost_done);
		merge = arbiter_valid && filling && (slot_block[fill_slot] == req_block) &&
			(slot_type[fill_slot] == arbiter_type);
		open_new = arbiter_valid && !merge;
		open_slot = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (slot_state[i] == empty)
				open_slot = slot_w'(i); // lowest empty wins
		end
		in_slot = merge ? fill_slot : open_slot;
	end

	always_comb begin
		ret_any = 1'b0;
		ret_slot = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (slot_state[i] == returning_data) begin
				ret_any = 1'b1;
				ret_slot = slot_w'(i);
			end
		end
		ret_mask = slot_mask[ret_slot];
		ret_onehot = ret_mask & (~ret_mask + 1'b1); // isolate lowest set bit
		ret_beat = '0;
		for (int b = 0; b < burst_length; b++) begin
			if (ret_onehot[b])
				ret_beat = beat_w'(b);
		end
		ret_done = ret_any && (ret_mask == '0);
	end

	always_comb begin
		for (int i = 0; i < no_of_bursts; i++) begin
			bif.state[i] = slot_state[i];
			bif.burst_type[i] = slot_type[i];
			bif.bank_group[i] = slot_block[i][25:24];
			bif.bank[i] = slot_block[i][23:22];
			bif.row[i] = slot_block[i][21:6];
			bif.col_block[i] = slot_block[i][5:0];
		end
	end

	assign beat.wr_data = slot_data[beat.beat_slot][beat.beat_num];
	assign beat.wr_mask = slot_mask[beat.beat_slot][beat.beat_num];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < no_of_bursts; i++) begin
				slot_state[i] <= empty;
				slot_mask[i] <= '0;
			end
			fill_slot <= '0;
			fill_cnt <= '0;
			empty_cnt <= (slot_w + 1)'(no_of_bursts);
			start_new_burst <= 1'b0;
			returner_valid <= 1'b0;
		end else begin
			start_new_burst <= (empty_cnt > 1) || (empty_cnt == 1 && !arbiter_valid);
			returner_valid <= 1'b0;
			if (merge) begin
				slot_mask[fill_slot][req_beat] <= 1'b1; // repeat column just overwrites
				fill_cnt <= fill_cnt + 1'b1;
				if (fill_cnt == 4'd7)
					slot_state[fill_slot] <= almost_done;
			end else begin
				if (filling)
					slot_state[fill_slot] <= full; // mismatch or idle cycle closes it
				if (open_new) begin
					slot_state[open_slot] <= started_filling;
					slot_mask[open_slot][req_beat] <= 1'b1;
					fill_slot <= open_slot;
					fill_cnt <= 4'd1;
				end
			end
			if (bif.cmd == read_cmd || bif.cmd == write_cmd)
				slot_state[bif.cmd_index] <= waiting;
			if (bif.data_done) begin
				for (int i = 0; i < no_of_bursts; i++) begin
					if (slot_state[i] == waiting)
						slot_state[i] <= returning_data; // one bank in flight
				end
			end
			if (ret_any && ret_mask != '0) begin
				slot_mask[ret_slot][ret_beat] <= 1'b0;
				returner_valid <= 1'b1;
			end
			if (ret_done)
				slot_state[ret_slot] <= empty;
			empty_cnt <= empty_cnt + (slot_w + 1)'(ret_done) - (slot_w + 1)'(open_new);
		end
	end

	always_ff @(posedge clk) begin
		if (open_new) begin
			slot_type[open_slot] <= arbiter_type;
			slot_block[open_slot] <= req_block;
		end
		if (arbiter_valid) begin
			slot_index[in_slot][req_beat] <= arbiter_index;
			if (arbiter_type == write)
				slot_data[in_slot][req_beat] <= arbiter_data;
		end
		if (beat.beat_valid && beat.beat_dir == read && beat.wr_mask)
			slot_data[beat.beat_slot][beat.beat_num] <= beat.rd_data;
		returner_type <= slot_type[ret_slot];
		returner_data <= slot_data[ret_slot][ret_beat]; // write data acts as the ack
		returner_index <= slot_index[ret_slot][ret_beat];
	end

	a_credit: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(arbiter_valid) |-> start_new_burst);

	a_no_empty_return: assert property (@(posedge clk) disable iff (!rst_n)
		returner_valid |-> $past(ret_mask[ret_beat]));

endmodule

/* burst_timing_ctrl.sv */
`timescale 1ns/1ps

module burst_timing_ctrl #(
	parameter int no_of_bursts = 4,
	parameter int t_gap = 4
) (
	input logic clk,
	input logic rst_n,
	burst_if.ctrl bif
);
	import ddr5_types_pkg::*;

	localparam int gap_w = $clog2(t_gap + 1);

	typedef enum logic [2:0] {
		idle,
		act_wait,
		rw_wait,
		data_wait,
		pre_wait
	} ctrl_state_t;

	ctrl_state_t state;
	logic [gap_w-1:0] gap;
	logic [$clog2(no_of_bursts)-1:0] slot, full_slot;
	logic full_any;

	always_comb begin
		full_any = 1'b0;
		full_slot = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (bif.state[i] == full) begin
				full_any = 1'b1;
				full_slot = i[$clog2(no_of_bursts)-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			gap <= '0;
			slot <= '0;
			bif.cmd <= none;
			bif.cmd_index <= '0;
		end else begin
			bif.cmd <= none;
			case (state)
				idle: if (full_any) begin
					bif.cmd <= activate;
					bif.cmd_index <= full_slot;
					slot <= full_slot;
					gap <= gap_w'(t_gap - 1);
					state <= rw_wait;
				end
				rw_wait: if (gap == '0) begin
					bif.cmd <= (bif.burst_type[slot] == write) ? write_cmd : read_cmd;
					bif.cmd_index <= slot;
					state <= data_wait;
				end else begin
					gap <= gap - 1'b1;
				end
				data_wait: if (bif.data_done) begin
					gap <= gap_w'(t_gap - 2); // precharge lands t_gap after done
					state <= pre_wait;
				end
				pre_wait: if (gap == '0) begin
					bif.cmd <= precharge;
					bif.cmd_index <= slot;
					gap <= gap_w'(t_gap - 1);
					state <= act_wait;
				end else begin
					gap <= gap - 1'b1;
				end
				act_wait: if (gap == '0) begin
					state <= idle; // next activate allowed
				end else begin
					gap <= gap - 1'b1;
				end
				default: state <= idle;
			endcase
		end
	end

	a_cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		bif.cmd != none |=> (bif.cmd == none) [*t_gap-1]);

endmodule

/* ddr5_cmd_phy.sv */
`timescale 1ns/1ps

module ddr5_cmd_phy #(
	parameter int no_of_bursts = 4,
	parameter int rd_to_data = 12,
	parameter int wr_to_data = 10
) (
	input  logic clk,
	input  logic rst_n,
	burst_if.phy bif,
	beat_if.phy beat,
	output logic CS_n,
	output logic [13:0] CA,
	output logic [2:0] DM_n,
	inout  wire [ddr5_types_pkg::data_width-1:0] DQ
);
	import ddr5_types_pkg::*;

	localparam int max_lat = (rd_to_data > wr_to_data) ? rd_to_data : wr_to_data;
	localparam int cnt_w = $clog2(max_lat);
	localparam int beat_w = $clog2(burst_length);

	command second_cmd; // command in its second CA cycle
	logic [$clog2(no_of_bursts)-1:0] second_slot;
	logic [3:0] bank_fields;
	logic [cnt_w-1:0] wait_cnt;
	logic data_pending;
	logic dq_drive;

	assign bank_fields = {bif.bank_group[bif.cmd_index], bif.bank[bif.cmd_index]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			CS_n <= 1'b1;
			CA <= '0;
			second_cmd <= none;
			second_slot <= '0;
		end else begin
			second_cmd <= bif.cmd;
			second_slot <= bif.cmd_index;
			if (bif.cmd != none) begin
				CS_n <= 1'b0; // first cycle only
				case (bif.cmd)
					activate:  CA <= {4'b0, bank_fields, bif.row[bif.cmd_index][3:0], 2'b00};
					read_cmd:  CA <= {4'b0, bank_fields, 1'b1, 5'b11101}; // bit 5 set, BL16
					write_cmd: CA <= {4'b0, bank_fields, 1'b1, 5'b01101};
					default:   CA <= {4'b0, bank_fields, 6'b011011}; // precharge
				endcase
			end else begin
				CS_n <= 1'b1;
				case (second_cmd)
					activate:            CA <= {2'b00, bif.row[second_slot][15:4]};
					read_cmd, write_cmd: CA <= {6'b0, bif.col_block[second_slot], 2'b00};
					default:             CA <= '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_pending <= 1'b0;
			wait_cnt <= '0;
			beat.beat_valid <= 1'b0;
			beat.beat_dir <= read;
			beat.beat_slot <= '0;
			beat.beat_num <= '0;
			bif.data_done <= 1'b0;
		end else begin
			bif.data_done <= 1'b0;
			if (bif.cmd == read_cmd || bif.cmd == write_cmd) begin
				data_pending <= 1'b1;
				wait_cnt <= cnt_w'(((bif.cmd == read_cmd) ? rd_to_data : wr_to_data) - 1);
				beat.beat_dir <= (bif.cmd == read_cmd) ? read : write;
				beat.beat_slot <= bif.cmd_index;
			end else if (data_pending) begin
				if (wait_cnt == '0) begin
					data_pending <= 1'b0;
					beat.beat_valid <= 1'b1; // beat 0 next cycle
					beat.beat_num <= '0;
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
			end
			if (beat.beat_valid) begin
				if (beat.beat_num == beat_w'(burst_length - 1)) begin
					beat.beat_valid <= 1'b0;
					bif.data_done <= 1'b1;
				end else begin
					beat.beat_num <= beat.beat_num + 1'b1;
				end
			end
		end
	end

	// DQ and DM_n follow the beat registers directly
	assign dq_drive = beat.beat_valid && (beat.beat_dir == write);
	assign DQ = dq_drive ? beat.wr_data : 'z;
	assign DM_n = (dq_drive && beat.wr_mask) ? 3'b000 : 3'b111; // low on masked-in beats
	assign beat.rd_data = DQ;

	a_write_window: assert property (@(posedge clk) disable iff (!rst_n)
		bif.cmd == write_cmd |-> ##(wr_to_data + 1) dq_drive [*burst_length] ##1 !dq_drive);

endmodule

/* ddr5_burst_top.sv */
`timescale 1ns/1ps

module ddr5_burst_top #(
	parameter int no_of_bursts = 4,
	parameter int rd_to_data = 12,
	parameter int wr_to_data = 10,
	parameter int t_gap = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic arbiter_valid,
	input  ddr5_types_pkg::r_type arbiter_type,
	input  ddr5_types_pkg::req_address_type in_req_address,
	input  logic [ddr5_types_pkg::data_width-1:0] arbiter_data,
	input  logic [ddr5_types_pkg::read_entries_log-1:0] arbiter_index,
	output logic start_new_burst,
	output logic CS_n,
	output logic [13:0] CA,
	output logic [2:0] DM_n,
	inout  wire [ddr5_types_pkg::data_width-1:0] DQ,
	output logic returner_valid,
	output ddr5_types_pkg::r_type returner_type,
	output logic [ddr5_types_pkg::data_width-1:0] returner_data,
	output logic [ddr5_types_pkg::read_entries_log-1:0] returner_index
);

	burst_if #(.no_of_bursts(no_of_bursts)) bif ();
	beat_if #(.no_of_bursts(no_of_bursts)) beat ();

	burst_store #(.no_of_bursts(no_of_bursts)) u_store (
		.clk(clk),
		.rst_n(rst_n),
		.arbiter_valid(arbiter_valid),
		.arbiter_type(arbiter_type),
		.in_req_address(in_req_address),
		.arbiter_data(arbiter_data),
		.arbiter_index(arbiter_index),
		.start_new_burst(start_new_burst),
		.returner_valid(returner_valid),
		.returner_type(returner_type),
		.returner_data(returner_data),
		.returner_index(returner_index),
		.bif(bif.store),
		.beat(beat.store)
	);

	burst_timing_ctrl #(.no_of_bursts(no_of_bursts), .t_gap(t_gap)) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.bif(bif.ctrl)
	);

	ddr5_cmd_phy #(
		.no_of_bursts(no_of_bursts),
		.rd_to_data(rd_to_data),
		.wr_to_data(wr_to_data)
	) u_phy (
		.clk(clk),
		.rst_n(rst_n),
		.bif(bif.phy),
		.beat(beat.phy),
		.CS_n(CS_n),
		.CA(CA),
		.DM_n(DM_n),
		.DQ(DQ)
	);

endmodule

/* ddr5_mem_model.sv */
`timescale 1ns/1ps

module ddr5_mem_model #(
	parameter int rd_to_data = 12,
	parameter int wr_to_data = 10
) (
	input logic clk,
	input logic CS_n,
	input logic [13:0] CA,
	input logic [2:0] DM_n,
	inout wire [15:0] DQ
);

	logic [15:0] mem [logic [29:0]];
	logic [19:0] open_row = '0; // bg, bank, row
	logic [5:0] blk = '0;
	logic [1:0] phase = '0; // 1 activate tail, 2 read/write tail
	logic is_wr = 1'b0;
	logic busy = 1'b0;
	int cyc = 0;
	int start = 0;
	logic dq_en = 1'b0;
	logic [15:0] dq_out = '0;

	function automatic logic [15:0] pattern(logic [29:0] a);
		return a[15:0]; // low bits of row and column
	endfunction

	function automatic logic [15:0] rd_word(logic [29:0] a);
		return mem.exists(a) ? mem[a] : pattern(a);
	endfunction

	assign DQ = dq_en ? dq_out : 'z;

	always @(posedge clk) begin
		int k;
		cyc = cyc + 1;
		if (!CS_n) begin
			if (CA[1:0] == 2'b00) begin
				open_row = {CA[9:8], CA[7:6], 12'h000, CA[5:2]};
				phase = 2'd1;
			end else if (CA[5:0] == 6'b011011) begin
				phase = 2'd0; // precharge
			end else begin
				is_wr = (CA[4:0] == 5'b01101);
				phase = 2'd2;
				start = cyc;
				busy = 1'b1;
			end
		end else if (phase == 2'd1) begin
			open_row[15:4] = CA[11:0];
			phase = 2'd0;
		end else if (phase == 2'd2) begin
			blk = CA[7:2];
			phase = 2'd0;
		end
		k = cyc - start;
		dq_en <= 1'b0;
		if (busy && !is_wr && k >= rd_to_data - 1 && k < rd_to_data + 15) begin
			dq_en <= 1'b1;
			dq_out <= rd_word({open_row, blk, 4'(k - rd_to_data + 1)});
		end
		if (busy && is_wr && k >= wr_to_data && k < wr_to_data + 16 && DM_n == 3'b000)
			mem[{open_row, blk, 4'(k - wr_to_data)}] = DQ; // masked-in beats only
	end

endmodule

/* tb_ddr5_burst.sv */
`timescale 1ns/1ps

module tb_ddr5_burst;
	import ddr5_types_pkg::*;

	localparam int timeout = 2000;

	logic clk, rst_n, arbiter_valid;
	r_type arbiter_type;
	req_address_type in_req_address;
	logic [15:0] arbiter_data;
	logic [3:0] arbiter_index;
	logic start_new_burst, CS_n, returner_valid;
	logic [13:0] CA;
	logic [2:0] DM_n;
	wire [15:0] DQ;
	r_type returner_type;
	logic [15:0] returner_data;
	logic [3:0] returner_index;

	logic [15:0] lfsr = 16'd84;
	logic [15:0] sb [logic [29:0]]; // expected memory contents
	logic [3:0] q_idx [$];
	r_type q_type [$];
	logic [15:0] q_data [$];
	int act_count = 0;
	int dm_low = 0; // write beats with DM_n all low
	req_address_type blk_addr;

	ddr5_burst_top uut (.*);
	ddr5_mem_model mem_m (.clk(clk), .CS_n(CS_n), .CA(CA), .DM_n(DM_n), .DQ(DQ));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(negedge clk) begin
		if (returner_valid) begin
			q_idx.push_back(returner_index);
			q_type.push_back(returner_type);
			q_data.push_back(returner_data);
		end
		if (rst_n && !CS_n && CA[1:0] == 2'b00)
			act_count++; // activate opcode
		if (rst_n && DM_n == 3'b000)
			dm_low++;
	end

	function automatic logic [15:0] next_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [15:0] exp_read(req_address_type a);
		return sb.exists(a) ? sb[a] : a[15:0];
	endfunction

	function automatic req_address_type rand_block();
		req_address_type r;
		r.bank_group = 2'(next_bits(2));
		r.bank = 2'(next_bits(2));
		r.row = next_bits(16);
		r.column = {6'(next_bits(6)), 4'h0};
		return r;
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic fail(string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run aborted");
	endtask

	task automatic wait_credit();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > timeout)
				fail("start_new_burst never went high");
		end while (!start_new_burst);
	endtask

	task automatic wait_returns(int base, int cnt);
		int n;
		n = 0;
		while (q_idx.size() < base + cnt) begin
			@(negedge clk);
			n++;
			if (n > timeout)
				fail("returns did not arrive in time");
		end
	endtask

	task automatic send(r_type t, req_address_type a, logic [15:0] d, logic [3:0] i);
		@(posedge clk);
		arbiter_valid <= 1'b1;
		arbiter_type <= t;
		in_req_address <= a;
		arbiter_data <= d;
		arbiter_index <= i;
	endtask

	task automatic idle();
		@(posedge clk);
		arbiter_valid <= 1'b0;
	endtask

	task automatic check_return(int p, logic [3:0] i, r_type t, logic [15:0] d);
		check("returner_index", q_idx[p], i);
		check("returner_type", q_type[p], t);
		check("returner_data", q_data[p], d);
	endtask

	task automatic reset_state();
		@(negedge clk);
		check("CS_n", CS_n, 1'b1);
		check("CA", CA, 14'h0);
		check("DM_n", DM_n, 3'b111);
		check("returner_valid", returner_valid, 1'b0);
		@(negedge clk);
		check("start_new_burst", start_new_burst, 1'b1);
	endtask

	task automatic single_read();
		req_address_type a;
		int base;
		a = rand_block();
		a.column[3:0] = next_bits(4);
		base = q_idx.size();
		wait_credit();
		send(read, a, 16'h0, 4'd9);
		idle();
		wait_returns(base, 1);
		check_return(base, 4'd9, read, exp_read(a));
	endtask

	task automatic full_block_write_read();
		req_address_type a;
		logic [15:0] d [16];
		int base, dm_base;
		blk_addr = rand_block();
		base = q_idx.size();
		wait_credit();
		dm_base = dm_low;
		for (int k = 0; k < 16; k++) begin
			a = blk_addr;
			a.column[3:0] = 4'(k);
			d[k] = next_bits(16);
			sb[a] = d[k];
			send(write, a, d[k], 4'(k));
		end
		idle();
		wait_returns(base, 16);
		for (int k = 0; k < 16; k++)
			check_return(base + k, 4'(k), write, d[k]);
		check("DM_n_low_beats", dm_low - dm_base, 16);
		base = q_idx.size();
		wait_credit();
		for (int k = 0; k < 16; k++) begin
			a = blk_addr;
			a.column[3:0] = 4'(k);
			send(read, a, 16'h0, 4'(15 - k));
		end
		idle();
		wait_returns(base, 16);
		for (int k = 0; k < 16; k++) begin
			a = blk_addr;
			a.column[3:0] = 4'(k);
			check_return(base + k, 4'(15 - k), read, exp_read(a));
		end
	endtask

	task automatic partial_write_read();
		int beats [5] = '{11, 1, 6, 12, 4};
		int sorted [5] = '{1, 4, 6, 11, 12};
		logic [15:0] d [16];
		req_address_type a;
		int base, dm_base;
		base = q_idx.size();
		wait_credit();
		dm_base = dm_low;
		foreach (beats[j]) begin
			a = blk_addr;
			a.column[3:0] = 4'(beats[j]);
			d[beats[j]] = next_bits(16);
			sb[a] = d[beats[j]];
			send(write, a, d[beats[j]], 4'(beats[j]));
		end
		idle();
		wait_returns(base, 5);
		foreach (sorted[j])
			check_return(base + j, 4'(sorted[j]), write, d[sorted[j]]);
		check("DM_n_low_beats", dm_low - dm_base, 5); // only the masked-in beats
		base = q_idx.size();
		wait_credit();
		for (int k = 0; k < 16; k++) begin
			a = blk_addr;
			a.column[3:0] = 4'(k);
			send(read, a, 16'h0, 4'(k));
		end
		idle();
		wait_returns(base, 16);
		for (int k = 0; k < 16; k++) begin
			a = blk_addr;
			a.column[3:0] = 4'(k);
			check_return(base + k, 4'(k), read, exp_read(a)); // old or new data
		end
	endtask

	task automatic burst_forming();
		int nb [4] = '{3, 1, 2, 1};
		int beats [7] = '{5, 2, 9, 0, 7, 3, 12};
		int exp_idx [7] = '{1, 0, 2, 3, 5, 4, 6}; // beat order within each burst
		req_address_type addr_of [7];
		req_address_type b;
		int base, acts, p;
		base = q_idx.size();
		acts = act_count;
		p = 0;
		for (int r = 0; r < 4; r++) begin
			b = rand_block();
			b.row[1:0] = 2'(r); // four distinct rows
			wait_credit();
			for (int j = 0; j < nb[r]; j++) begin
				addr_of[p] = b;
				addr_of[p].column[3:0] = 4'(beats[p]);
				send(read, addr_of[p], 16'h0, 4'(p));
				p++;
			end
			idle();
		end
		wait_returns(base, 7);
		foreach (exp_idx[j])
			check_return(base + j, 4'(exp_idx[j]), read, exp_read(addr_of[exp_idx[j]]));
		repeat (16) @(negedge clk); // quiet window after the last return
		check("activate_count", act_count - acts, 4);
		check("return_count", q_idx.size() - base, 7);
	endtask

	task automatic credit_tracking();
		req_address_type a;
		logic [15:0] d [4];
		logic exp_sn, v;
		int e, base, w;
		repeat (4) idle();
		base = q_idx.size();
		e = 4;
		exp_sn = 1'b1;
		w = 0;
		for (int i = 0; i < 8; i++) begin
			v = (i % 2 == 0);
			if (v) begin
				a = rand_block();
				d[w] = next_bits(16);
				sb[a] = d[w];
				send(write, a, d[w], 4'(w));
				w++;
			end else begin
				idle();
			end
			@(negedge clk);
			check("start_new_burst", start_new_burst, exp_sn);
			check("early_returns", q_idx.size() - base, 0);
			exp_sn = (e > 1) || (e == 1 && !v); // registered credit rule
			if (v)
				e--;
		end
		wait_returns(base, 4);
		for (int k = 0; k < 4; k++)
			check_return(base + k, 4'(k), write, d[k]);
	endtask

	initial begin
		rst_n = 1'b0;
		arbiter_valid = 1'b0;
		arbiter_type = read;
		in_req_address = '0;
		arbiter_data = '0;
		arbiter_index = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		reset_state();
		single_read();
		full_block_write_read();
		partial_write_read();
		burst_forming();
		credit_tracking();
		repeat (4) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* ddr5_burst.f */
ddr5_types_pkg.sv
burst_if.sv
beat_if.sv
burst_store.sv
burst_timing_ctrl.sv
ddr5_cmd_phy.sv
ddr5_burst_top.sv
ddr5_mem_model.sv
tb_ddr5_burst.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_ddr5_burst
FLAGS ?= --binary --timing --assert -Wno-fatal
FILELIST ?= ddr5_burst.f
OBJ_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
